// File: source/wbh_pkg.sv
// wishbone host bridge shared definitions
// bus widths, local address map, register offsets,
// reset values and the global control word layout
package wbh_pkg;

   //----------------------------------------
   // bus widths
   //----------------------------------------
   localparam int WB_AW = 32;             // address width
   localparam int WB_DW = 32;             // data width
   localparam int WB_SW = 4;              // byte selects

   //----------------------------------------
   // address map
   //----------------------------------------
   localparam int LOC_SEL_BIT = 23;       // set for local register bank
   localparam int BANK_AW     = 8;        // bank select width, top of slave address
   localparam int ADR_LOW_W   = 24;       // request bits passed through to slave
   localparam int REG_OFS_LSB = 2;        // word offset, two bits wide

   // local register offsets
   localparam logic [1:0] REG_GLB  = 2'd0;   // global control
   localparam logic [1:0] REG_BANK = 2'd1;   // bank select
   localparam logic [1:0] REG_CLK1 = 2'd2;   // clock control 1
   localparam logic [1:0] REG_CLK2 = 2'd3;   // clock control 2

   // reset values
   localparam logic [BANK_AW-1:0] BANK_RST_VAL = 8'h10;

   localparam int N_PERIPH_RST = 8;       // active low peripheral resets

   // slave forward stage states
   localparam logic [1:0] FWD_IDLE = 2'd0;   // waiting for slv_req
   localparam logic [1:0] FWD_BUSY = 2'd1;   // slave cycle out
   localparam logic [1:0] FWD_DONE = 2'd2;   // ack pulse out, no relaunch

   //----------------------------------------
   // global control word
   //----------------------------------------
   // field view, msb first
   typedef struct packed {
      logic [3:0]              usb_clk_ctrl;   // 31:28
      logic [3:0]              rsvd;           // 27:24
      logic [3:0]              cpu_clk_ctrl;   // 23:20
      logic [7:0]              rtc_clk_ctrl;   // 19:12
      logic [3:0]              wb_clk_ctrl;    // 11:8
      logic [N_PERIPH_RST-1:0] periph_rst_n;   // 7:0
   } glb_ctrl_fld_t;

   // raw word for bus writes and readback,
   // fields for the reset outputs
   typedef union packed {
      logic [WB_DW-1:0] raw;
      glb_ctrl_fld_t    fld;
   } glb_ctrl_u;

endpackage

// File: source/wbh_req_ctrl.sv
// wishbone host request control
// registers the master strobe into a request flag, steers it
// to the local bank or the slave stage by address bit 23,
// and registers ack, error and read data back to the master
`timescale 1ns/1ps

module wbh_req_ctrl (
   input  logic                      wbm_clk_i,
   input  logic                      wbm_rst_n,
   input  logic                      wbm_stb_i,     // qualified by cyc at top
   input  logic [wbh_pkg::WB_AW-1:0] wbm_adr_i,
   input  logic                      loc_ack_i,     // one cycle pulse
   input  logic [wbh_pkg::WB_DW-1:0] loc_rdata_i,
   input  logic                      slv_ack_i,     // one cycle pulse
   input  logic                      slv_err_i,     // valid with slv_ack_i
   input  logic [wbh_pkg::WB_DW-1:0] slv_rdata_i,
   output logic                      loc_req_o,
   output logic                      slv_req_o,
   output logic [wbh_pkg::WB_DW-1:0] wbm_dat_o,
   output logic                      wbm_ack_o,
   output logic                      wbm_err_o
);

   logic                      wb_req;    // request flag
   logic                      loc_sel;   // bit 23 decode
   logic                      rsp_ack;   // ack from active block
   logic                      rsp_err;
   logic [wbh_pkg::WB_DW-1:0] rsp_dat;

   //----------------------------------------
   // target decode
   //----------------------------------------
   assign loc_sel   = wbm_adr_i[wbh_pkg::LOC_SEL_BIT];
   assign loc_req_o = wb_req & loc_sel;
   assign slv_req_o = wb_req & ~loc_sel;   // exactly one strobe while wb_req

   // response mux, local bank never errors
   always_comb
   begin
      if (loc_sel)
      begin
         rsp_ack = loc_ack_i;
         rsp_err = 1'b0;
         rsp_dat = loc_rdata_i;
      end
      else
      begin
         rsp_ack = slv_ack_i;
         rsp_err = slv_err_i;
         rsp_dat = slv_rdata_i;
      end
   end

   //----------------------------------------
   // request flag and master response
   //----------------------------------------
   // flag drops on the edge that samples the block ack and
   // stays low while the registered ack is out, so the held
   // strobe cannot relaunch before the master lets go
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         wb_req    <= 1'b0;
         wbm_ack_o <= 1'b0;
         wbm_err_o <= 1'b0;
         wbm_dat_o <= '0;
      end
      else
      begin
         wb_req    <= wbm_stb_i & ~rsp_ack & ~wbm_ack_o;
         wbm_ack_o <= rsp_ack;             // ends every transfer
         wbm_err_o <= rsp_ack & rsp_err;   // qualifies the ack
         // hold last data on the bus
         if (rsp_ack && !rsp_err)
         begin
            wbm_dat_o <= rsp_dat;          // errored reads keep old data
         end
      end
   end

endmodule

// File: source/wbh_reg_bank.sv
// local register bank of the wishbone host
// four words: global control, bank select and two clock
// control words, with write decode, registered readback
// and a single-cycle local ack per request
`timescale 1ns/1ps

module wbh_reg_bank (
   input  logic                             wbm_clk_i,
   input  logic                             wbm_rst_n,
   input  logic                             loc_req_i,
   input  logic [wbh_pkg::WB_AW-1:0]        wbm_adr_i,
   input  logic                             wbm_we_i,
   input  logic [wbh_pkg::WB_DW-1:0]        wbm_dat_i,
   output logic                             loc_ack_o,
   output logic [wbh_pkg::WB_DW-1:0]        loc_rdata_o,
   output logic [wbh_pkg::BANK_AW-1:0]      bank_sel_o,
   output logic [wbh_pkg::N_PERIPH_RST-1:0] periph_rst_n_o,
   output logic [wbh_pkg::WB_DW-1:0]        cfg_clk_ctrl1_o,
   output logic [wbh_pkg::WB_DW-1:0]        cfg_clk_ctrl2_o
);

   logic [1:0]                reg_ofs;    // word offset
   logic                      acc_go;     // accepted access, ack not yet out
   logic                      wr_go;
   logic                      wr_glb;
   logic                      wr_bank;
   logic                      wr_clk1;
   logic                      wr_clk2;
   logic [wbh_pkg::WB_DW-1:0] rd_mux;     // readback select
   wbh_pkg::glb_ctrl_u        glb_ctrl;   // global control word

   //----------------------------------------
   // write decode
   //----------------------------------------
   assign reg_ofs = wbm_adr_i[wbh_pkg::REG_OFS_LSB +: 2];
   assign acc_go  = loc_req_i & ~loc_ack_o;   // req still high during ack
   assign wr_go   = acc_go & wbm_we_i;

   assign wr_glb  = wr_go & (reg_ofs == wbh_pkg::REG_GLB);
   assign wr_bank = wr_go & (reg_ofs == wbh_pkg::REG_BANK);
   assign wr_clk1 = wr_go & (reg_ofs == wbh_pkg::REG_CLK1);
   assign wr_clk2 = wr_go & (reg_ofs == wbh_pkg::REG_CLK2);

   //----------------------------------------
   // config registers
   //----------------------------------------
   // writes land on the same edge as the ack
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         glb_ctrl.raw    <= '0;                     // peripherals held in reset
         bank_sel_o      <= wbh_pkg::BANK_RST_VAL;
         cfg_clk_ctrl1_o <= '0;
         cfg_clk_ctrl2_o <= '0;
      end
      else
      begin
         if (wr_glb)
         begin
            glb_ctrl.raw <= wbm_dat_i;
         end
         if (wr_bank)
         begin
            bank_sel_o <= wbm_dat_i[wbh_pkg::BANK_AW-1:0];   // low byte only
         end
         if (wr_clk1)
         begin
            cfg_clk_ctrl1_o <= wbm_dat_i;
         end
         if (wr_clk2)
         begin
            cfg_clk_ctrl2_o <= wbm_dat_i;
         end
      end
   end

   // active low resets straight from the low byte
   assign periph_rst_n_o = glb_ctrl.fld.periph_rst_n;

   //----------------------------------------
   // readback
   //----------------------------------------
   always_comb
   begin
      case (reg_ofs)
         wbh_pkg::REG_GLB:  rd_mux = glb_ctrl.raw;
         wbh_pkg::REG_BANK: rd_mux = {{(wbh_pkg::WB_DW - wbh_pkg::BANK_AW){1'b0}}, bank_sel_o};
         wbh_pkg::REG_CLK1: rd_mux = cfg_clk_ctrl1_o;
         wbh_pkg::REG_CLK2: rd_mux = cfg_clk_ctrl2_o;
         default:           rd_mux = '0;
      endcase
   end

   // one ack pulse per request, read data with it
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         loc_ack_o   <= 1'b0;
         loc_rdata_o <= '0;
      end
      else
      begin
         loc_ack_o <= acc_go;
         if (acc_go && !wbm_we_i)
         begin
            loc_rdata_o <= rd_mux;
         end
      end
   end

endmodule

// File: source/wbh_slave_fwd.sv
// registered request stage toward the downstream slave
// launches one wishbone cycle per request with the bank byte
// on top of address bits 23:0, and turns the slave ack or
// error into a one-cycle pulse back to request control
`timescale 1ns/1ps

module wbh_slave_fwd (
   input  logic                        wbm_clk_i,
   input  logic                        wbm_rst_n,
   input  logic                        slv_req_i,
   input  logic [wbh_pkg::WB_AW-1:0]   wbm_adr_i,
   input  logic                        wbm_we_i,
   input  logic [wbh_pkg::WB_DW-1:0]   wbm_dat_i,
   input  logic [wbh_pkg::WB_SW-1:0]   wbm_sel_i,
   input  logic [wbh_pkg::BANK_AW-1:0] bank_sel_i,
   input  logic [wbh_pkg::WB_DW-1:0]   wbs_dat_i,
   input  logic                        wbs_ack_i,
   input  logic                        wbs_err_i,
   output logic                        slv_ack_o,
   output logic                        slv_err_o,
   output logic [wbh_pkg::WB_DW-1:0]   slv_rdata_o,
   output logic                        wbs_cyc_o,
   output logic                        wbs_stb_o,
   output logic [wbh_pkg::WB_AW-1:0]   wbs_adr_o,
   output logic                        wbs_we_o,
   output logic [wbh_pkg::WB_DW-1:0]   wbs_dat_o,
   output logic [wbh_pkg::WB_SW-1:0]   wbs_sel_o
);

   logic [1:0] fwd_st;    // idle / busy / done
   logic       launch;    // start slave cycle
   logic       capture;   // slave answered

   assign launch  = (fwd_st == wbh_pkg::FWD_IDLE) & slv_req_i;
   assign capture = (fwd_st == wbh_pkg::FWD_BUSY) & (wbs_ack_i | wbs_err_i);

   //----------------------------------------
   // stage control
   //----------------------------------------
   always_ff @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         fwd_st    <= wbh_pkg::FWD_IDLE;
         wbs_cyc_o <= 1'b0;
         wbs_stb_o <= 1'b0;
         slv_ack_o <= 1'b0;
         slv_err_o <= 1'b0;
      end
      else
      begin
         case (fwd_st)
            wbh_pkg::FWD_IDLE:
            begin
               if (launch)
               begin
                  wbs_cyc_o <= 1'b1;
                  wbs_stb_o <= 1'b1;
                  fwd_st    <= wbh_pkg::FWD_BUSY;
               end
            end
            wbh_pkg::FWD_BUSY:
            begin
               if (capture)                     // wait states stretch here
               begin
                  wbs_cyc_o <= 1'b0;
                  wbs_stb_o <= 1'b0;
                  slv_ack_o <= 1'b1;
                  slv_err_o <= wbs_err_i;
                  fwd_st    <= wbh_pkg::FWD_DONE;
               end
            end
            wbh_pkg::FWD_DONE:
            begin
               slv_ack_o <= 1'b0;               // req still high this cycle
               slv_err_o <= 1'b0;
               fwd_st    <= wbh_pkg::FWD_IDLE;
            end
            default: fwd_st <= wbh_pkg::FWD_IDLE;
         endcase
      end
   end

   //----------------------------------------
   // payload
   //----------------------------------------
   always_ff @(posedge wbm_clk_i)
   begin
      if (launch)
      begin
         // bank byte widens the 16MB window
         wbs_adr_o <= {bank_sel_i, wbm_adr_i[wbh_pkg::ADR_LOW_W-1:0]};
         wbs_we_o  <= wbm_we_i;
         wbs_dat_o <= wbm_dat_i;
         wbs_sel_o <= wbm_sel_i;
      end
      if (capture)
      begin
         slv_rdata_o <= wbs_dat_i;
      end
   end

endmodule

// File: source/wb_host.sv
// wishbone host bridge top level
// one master port, bit 23 picks the local register bank
// or the downstream slave port with bank-widened address
`timescale 1ns/1ps

module wb_host (
   input  logic                             wbm_clk_i,
   input  logic                             wbm_rst_n,
   // master port
   input  logic                             wbm_cyc_i,
   input  logic                             wbm_stb_i,
   input  logic [wbh_pkg::WB_AW-1:0]        wbm_adr_i,
   input  logic                             wbm_we_i,
   input  logic [wbh_pkg::WB_DW-1:0]        wbm_dat_i,
   input  logic [wbh_pkg::WB_SW-1:0]        wbm_sel_i,
   output logic [wbh_pkg::WB_DW-1:0]        wbm_dat_o,
   output logic                             wbm_ack_o,
   output logic                             wbm_err_o,
   // slave port
   output logic                             wbs_cyc_o,
   output logic                             wbs_stb_o,
   output logic [wbh_pkg::WB_AW-1:0]        wbs_adr_o,
   output logic                             wbs_we_o,
   output logic [wbh_pkg::WB_DW-1:0]        wbs_dat_o,
   output logic [wbh_pkg::WB_SW-1:0]        wbs_sel_o,
   input  logic [wbh_pkg::WB_DW-1:0]        wbs_dat_i,
   input  logic                             wbs_ack_i,
   input  logic                             wbs_err_i,
   // config outputs
   output logic [wbh_pkg::N_PERIPH_RST-1:0] periph_rst_n_o,
   output logic [wbh_pkg::WB_DW-1:0]        cfg_clk_ctrl1_o,
   output logic [wbh_pkg::WB_DW-1:0]        cfg_clk_ctrl2_o
);

   //----------------------------------------
   // internal request / response wires
   //----------------------------------------
   logic                        loc_req;     // to reg bank
   logic                        slv_req;     // to slave stage
   logic                        loc_ack;
   logic [wbh_pkg::WB_DW-1:0]   loc_rdata;
   logic                        slv_ack;
   logic                        slv_err;
   logic [wbh_pkg::WB_DW-1:0]   slv_rdata;
   logic [wbh_pkg::BANK_AW-1:0] bank_sel;    // top address byte

   // strobe only counts inside a bus cycle
   wbh_req_ctrl u_req_ctrl (
      .wbm_clk_i   (wbm_clk_i),
      .wbm_rst_n   (wbm_rst_n),
      .wbm_stb_i   (wbm_stb_i & wbm_cyc_i),
      .wbm_adr_i   (wbm_adr_i),
      .loc_ack_i   (loc_ack),
      .loc_rdata_i (loc_rdata),
      .slv_ack_i   (slv_ack),
      .slv_err_i   (slv_err),
      .slv_rdata_i (slv_rdata),
      .loc_req_o   (loc_req),
      .slv_req_o   (slv_req),
      .wbm_dat_o   (wbm_dat_o),
      .wbm_ack_o   (wbm_ack_o),
      .wbm_err_o   (wbm_err_o)
   );

   // local registers
   wbh_reg_bank u_reg_bank (
      .wbm_clk_i       (wbm_clk_i),
      .wbm_rst_n       (wbm_rst_n),
      .loc_req_i       (loc_req),
      .wbm_adr_i       (wbm_adr_i),
      .wbm_we_i        (wbm_we_i),
      .wbm_dat_i       (wbm_dat_i),
      .loc_ack_o       (loc_ack),
      .loc_rdata_o     (loc_rdata),
      .bank_sel_o      (bank_sel),
      .periph_rst_n_o  (periph_rst_n_o),
      .cfg_clk_ctrl1_o (cfg_clk_ctrl1_o),
      .cfg_clk_ctrl2_o (cfg_clk_ctrl2_o)
   );

   // downstream slave stage
   wbh_slave_fwd u_slave_fwd (
      .wbm_clk_i   (wbm_clk_i),
      .wbm_rst_n   (wbm_rst_n),
      .slv_req_i   (slv_req),
      .wbm_adr_i   (wbm_adr_i),
      .wbm_we_i    (wbm_we_i),
      .wbm_dat_i   (wbm_dat_i),
      .wbm_sel_i   (wbm_sel_i),
      .bank_sel_i  (bank_sel),
      .wbs_dat_i   (wbs_dat_i),
      .wbs_ack_i   (wbs_ack_i),
      .wbs_err_i   (wbs_err_i),
      .slv_ack_o   (slv_ack),
      .slv_err_o   (slv_err),
      .slv_rdata_o (slv_rdata),
      .wbs_cyc_o   (wbs_cyc_o),
      .wbs_stb_o   (wbs_stb_o),
      .wbs_adr_o   (wbs_adr_o),
      .wbs_we_o    (wbs_we_o),
      .wbs_dat_o   (wbs_dat_o),
      .wbs_sel_o   (wbs_sel_o)
   );

endmodule

// File: dv/tb_wbh_slave_model.sv
// downstream wishbone slave model for the host bridge testbench
// random 0 to 3 wait states, 16-word store, error on address bit 22
`timescale 1ns/1ps

module tb_wbh_slave_model (
   input  logic        wbm_clk_i,
   input  logic        wbm_rst_n,
   input  logic        wbs_cyc_i,
   input  logic        wbs_stb_i,
   input  logic [31:0] wbs_adr_i,
   input  logic        wbs_we_i,
   input  logic [31:0] wbs_dat_i,
   input  logic [3:0]  wbs_sel_i,
   output logic [31:0] wbs_dat_o,
   output logic        wbs_ack_o,
   output logic        wbs_err_o
);

   logic [31:0] mem [16];     // indexed by adr 5:2
   logic [15:0] written;      // word holds a stored write
   logic [31:0] seed;         // lcg state
   logic [31:0] nxt_seed;
   logic [1:0]  first_wait;   // wait states for a new cycle
   logic [1:0]  wait_left;
   logic        busy;         // cycle seen, still waiting
   logic        go;           // answer on this edge
   logic [3:0]  idx;
   logic [31:0] rd_word;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // byte lanes from the new word where sel is set
   function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                               input logic [31:0] nw,
                                               input logic [3:0]  sel);
      logic [31:0] m;
      int          b;
      m = old;
      for (b = 0; b < 4; b++)
      begin
         if (sel[b])
         begin
            m[8*b +: 8] = nw[8*b +: 8];
         end
      end
      return m;
   endfunction

   assign idx        = wbs_adr_i[5:2];
   assign nxt_seed   = lcg_next(seed);
   assign first_wait = nxt_seed[25:24];        // upper bits, better spread
   assign go         = busy ? (wait_left == 2'd0) : (first_wait == 2'd0);
   // unwritten words follow the address
   assign rd_word    = written[idx] ? mem[idx] : (wbs_adr_i ^ 32'hA5A5_0000);

   always @(posedge wbm_clk_i or negedge wbm_rst_n)
   begin
      if (!wbm_rst_n)
      begin
         seed      <= 32'h2939;
         written   <= '0;
         busy      <= 1'b0;
         wait_left <= 2'd0;
         wbs_ack_o <= 1'b0;
         wbs_err_o <= 1'b0;
         wbs_dat_o <= '0;
      end
      else if (wbs_ack_o || wbs_err_o)
      begin
         wbs_ack_o <= 1'b0;                   // single cycle answer
         wbs_err_o <= 1'b0;
      end
      else if (wbs_cyc_i && wbs_stb_i)
      begin
         if (!busy)
         begin
            seed <= nxt_seed;                 // one draw per cycle
         end
         if (go)
         begin
            busy <= 1'b0;
            if (wbs_adr_i[22])
            begin
               wbs_err_o <= 1'b1;             // error window, no store
            end
            else
            begin
               wbs_ack_o <= 1'b1;
               if (wbs_we_i)
               begin
                  mem[idx]     <= merge_bytes(rd_word, wbs_dat_i, wbs_sel_i);
                  written[idx] <= 1'b1;
               end
               else
               begin
                  wbs_dat_o <= rd_word;
               end
            end
         end
         else if (!busy)
         begin
            busy      <= 1'b1;
            wait_left <= first_wait - 2'd1;
         end
         else
         begin
            wait_left <= wait_left - 2'd1;
         end
      end
   end

endmodule

// File: dv/tb_wb_host.sv
// testbench for the wishbone host bridge
// runs a table of local and slave transfers through the master
// port, checks data, error, ack timing, slave address and the
// config outputs against a register model kept in the bench
`timescale 1ns/1ps

module tb_wb_host;

   localparam int CLK_PERIOD = 40;
   localparam int N_TXN      = 26;
   localparam int MAX_WAIT   = 20;              // cycles per transfer

   // local register addresses, bit 23 set
   localparam logic [31:0] A_GLB  = 32'h0080_0000;
   localparam logic [31:0] A_BANK = 32'h0080_0004;
   localparam logic [31:0] A_CLK1 = 32'h0080_0008;
   localparam logic [31:0] A_CLK2 = 32'h0080_000C;

   logic        wbm_clk_i = 1'b0;
   logic        wbm_rst_n;
   logic        wbm_cyc_i;
   logic        wbm_stb_i;
   logic [31:0] wbm_adr_i;
   logic        wbm_we_i;
   logic [31:0] wbm_dat_i;
   logic [3:0]  wbm_sel_i;
   logic [31:0] wbm_dat_o;
   logic        wbm_ack_o;
   logic        wbm_err_o;
   logic        wbs_cyc_o;
   logic        wbs_stb_o;
   logic [31:0] wbs_adr_o;
   logic        wbs_we_o;
   logic [31:0] wbs_dat_o;
   logic [3:0]  wbs_sel_o;
   logic [31:0] wbs_dat_i;
   logic        wbs_ack_i;
   logic        wbs_err_i;
   logic [7:0]  periph_rst_n_o;
   logic [31:0] cfg_clk_ctrl1_o;
   logic [31:0] cfg_clk_ctrl2_o;

   //----------------------------------------
   // transfer table
   //----------------------------------------
   string       t_name [N_TXN];
   logic        t_we   [N_TXN];
   logic [31:0] t_adr  [N_TXN];
   logic [31:0] t_dat  [N_TXN];
   logic [3:0]  t_sel  [N_TXN];
   logic [31:0] t_exp  [N_TXN];    // read data, held data on error
   logic        t_err  [N_TXN];
   int          n_load;

   // expected register state
   wbh_pkg::glb_ctrl_u exp_glb;
   logic [7:0]         exp_bank;
   logic [31:0]        exp_clk1;
   logic [31:0]        exp_clk2;

   int err_cnt;
   int test_err;
   int txn_idx;

   always #(CLK_PERIOD / 2) wbm_clk_i = ~wbm_clk_i;

   wb_host u_dut (.*);

   tb_wbh_slave_model u_slave (
      .wbm_clk_i (wbm_clk_i),
      .wbm_rst_n (wbm_rst_n),
      .wbs_cyc_i (wbs_cyc_o),
      .wbs_stb_i (wbs_stb_o),
      .wbs_adr_i (wbs_adr_o),
      .wbs_we_i  (wbs_we_o),
      .wbs_dat_i (wbs_dat_o),
      .wbs_sel_i (wbs_sel_o),
      .wbs_dat_o (wbs_dat_i),
      .wbs_ack_o (wbs_ack_i),
      .wbs_err_o (wbs_err_i)
   );

   task automatic add_txn(input string name, input logic we, input logic [31:0] adr,
                          input logic [31:0] dat, input logic [3:0] sel,
                          input logic [31:0] exp, input logic err);
      t_name[n_load] = name;
      t_we[n_load]   = we;
      t_adr[n_load]  = adr;
      t_dat[n_load]  = dat;
      t_sel[n_load]  = sel;
      t_exp[n_load]  = exp;
      t_err[n_load]  = err;
      n_load++;
   endtask

   task automatic check_val(input string sig, input logic [31:0] got,
                            input logic [31:0] exp);
      if (got !== exp)
      begin
         err_cnt++;
         $display("ERR t=%0t %s got=%h exp=%h", $time, sig, got, exp);
      end
   endtask

   // register model, bank select keeps the low byte
   task automatic update_regs(input logic [31:0] adr, input logic [31:0] dat);
      case (adr[wbh_pkg::REG_OFS_LSB +: 2])
         wbh_pkg::REG_GLB:  exp_glb.raw = dat;
         wbh_pkg::REG_BANK: exp_bank    = dat[wbh_pkg::BANK_AW-1:0];
         wbh_pkg::REG_CLK1: exp_clk1    = dat;
         default:           exp_clk2    = dat;
      endcase
   endtask

   task automatic load_table();
      add_txn("rd glb reset",  1'b0, A_GLB,  '0, 4'hF, 32'h0000_0000, 1'b0);
      add_txn("rd bank reset", 1'b0, A_BANK, '0, 4'hF, 32'h0000_0010, 1'b0);
      add_txn("rd clk1 reset", 1'b0, A_CLK1, '0, 4'hF, 32'h0000_0000, 1'b0);
      add_txn("rd clk2 reset", 1'b0, A_CLK2, '0, 4'hF, 32'h0000_0000, 1'b0);
      add_txn("wr glb",  1'b1, A_GLB,  32'h3C5A_96A5, 4'hF, '0, 1'b0);
      add_txn("rd glb",  1'b0, A_GLB,  '0, 4'hF, 32'h3C5A_96A5, 1'b0);
      add_txn("wr clk1", 1'b1, A_CLK1, 32'h1234_5678, 4'hF, '0, 1'b0);
      add_txn("wr clk2", 1'b1, A_CLK2, 32'h8765_4321, 4'hF, '0, 1'b0);
      add_txn("rd clk1", 1'b0, A_CLK1, '0, 4'hF, 32'h1234_5678, 1'b0);
      add_txn("rd clk2", 1'b0, A_CLK2, '0, 4'hF, 32'h8765_4321, 1'b0);
      add_txn("wr bank 5a", 1'b1, A_BANK, 32'hFFFF_FF5A, 4'hF, '0, 1'b0);
      add_txn("rd bank 5a", 1'b0, A_BANK, '0, 4'hF, 32'h0000_005A, 1'b0);
      add_txn("slv wr 10", 1'b1, 32'h0000_0010, 32'hDEAD_BEEF, 4'hF, '0, 1'b0);
      add_txn("slv rd 10", 1'b0, 32'h0000_0010, '0, 4'hF, 32'hDEAD_BEEF, 1'b0);
      add_txn("slv rd unwritten", 1'b0, 32'h0012_3424, '0, 4'hF,
              32'h5A12_3424 ^ 32'hA5A5_0000, 1'b0);
      add_txn("slv wr 20", 1'b1, 32'h0000_0020, 32'h0BAD_F00D, 4'hF, '0, 1'b0);
      add_txn("slv wr 20 low half", 1'b1, 32'h0000_0020, 32'hFFFF_1234, 4'h3, '0, 1'b0);
      add_txn("slv rd 20", 1'b0, 32'h0000_0020, '0, 4'hF, 32'h0BAD_1234, 1'b0);
      add_txn("slv rd error", 1'b0, 32'h0040_0004, '0, 4'hF, 32'h0BAD_1234, 1'b1);
      add_txn("slv wr error", 1'b1, 32'h0040_0008, 32'h5555_AAAA, 4'hF, 32'h0BAD_1234, 1'b1);
      add_txn("wr bank 81", 1'b1, A_BANK, 32'h0000_0081, 4'hF, '0, 1'b0);
      add_txn("rd bank 81", 1'b0, A_BANK, '0, 4'hF, 32'h0000_0081, 1'b0);
      add_txn("slv rd bank 81", 1'b0, 32'h0000_0030, '0, 4'hF,
              32'h8100_0030 ^ 32'hA5A5_0000, 1'b0);
      add_txn("slv rd alias 10", 1'b0, 32'h0010_0010, '0, 4'hF, 32'hDEAD_BEEF, 1'b0);
      add_txn("wr glb resets off", 1'b1, A_GLB, 32'h0000_00FF, 4'hF, '0, 1'b0);
      add_txn("rd glb resets off", 1'b0, A_GLB, '0, 4'hF, 32'h0000_00FF, 1'b0);
   endtask

   //----------------------------------------
   // one master transfer
   //----------------------------------------
   task automatic run_txn(input int i);
      int          cycles;
      logic        loc;
      logic        stb_seen;
      logic [31:0] exp_adr;
      loc      = t_adr[i][wbh_pkg::LOC_SEL_BIT];
      exp_adr  = {exp_bank, t_adr[i][wbh_pkg::ADR_LOW_W-1:0]};   // widened address
      cycles   = 0;
      stb_seen = 1'b0;
      @(posedge wbm_clk_i);
      wbm_cyc_i <= 1'b1;
      wbm_stb_i <= 1'b1;
      wbm_adr_i <= t_adr[i];
      wbm_we_i  <= t_we[i];
      wbm_dat_i <= t_dat[i];
      wbm_sel_i <= t_sel[i];
      do
      begin
         @(negedge wbm_clk_i);                  // outputs settled here
         cycles++;
         if (wbs_stb_o && !stb_seen)
         begin
            stb_seen = 1'b1;
            check_val("wbs_adr_o", wbs_adr_o, exp_adr);
            check_val("wbs_we_o", 32'(wbs_we_o), 32'(t_we[i]));
            check_val("wbs_cyc_o", 32'(wbs_cyc_o), 32'd1);
            check_val("wbs_sel_o", 32'(wbs_sel_o), 32'(t_sel[i]));
            if (t_we[i])
            begin
               check_val("wbs_dat_o", wbs_dat_o, t_dat[i]);
            end
         end
      end
      while (!wbm_ack_o && cycles < MAX_WAIT);
      if (!wbm_ack_o)
      begin
         err_cnt++;
         $display("no ack for %s within %0d cycles", t_name[i], MAX_WAIT);
      end
      else
      begin
         if (loc)
         begin
            check_val("ack_cycles", 32'(cycles), 32'd4);   // third edge, next negedge
         end
         else if (cycles < 6 || cycles > 9)
         begin
            err_cnt++;
            $display("slave transfer %s took %0d cycles, not 6 to 9", t_name[i], cycles);
         end
         if (loc && stb_seen)
         begin
            err_cnt++;
            $display("local access %s reached the slave port", t_name[i]);
         end
         if (!loc && !stb_seen)
         begin
            err_cnt++;
            $display("slave access %s never raised wbs_stb_o", t_name[i]);
         end
         check_val("wbs_cyc_o", 32'(wbs_cyc_o), 32'd0);      // slave cycle closed
         check_val("wbm_err_o", 32'(wbm_err_o), 32'(t_err[i]));
         if (!t_we[i] || t_err[i])
         begin
            check_val("wbm_dat_o", wbm_dat_o, t_exp[i]);
         end
         if (loc && t_we[i])
         begin
            update_regs(t_adr[i], t_dat[i]);
         end
         check_val("periph_rst_n_o", 32'(periph_rst_n_o), 32'(exp_glb.fld.periph_rst_n));
         check_val("cfg_clk_ctrl1_o", cfg_clk_ctrl1_o, exp_clk1);
         check_val("cfg_clk_ctrl2_o", cfg_clk_ctrl2_o, exp_clk2);
      end
      @(posedge wbm_clk_i);
      wbm_cyc_i <= 1'b0;                        // release after the ack
      wbm_stb_i <= 1'b0;
      @(negedge wbm_clk_i);
      if (wbm_ack_o)
      begin
         err_cnt++;
         $display("wbm_ack_o stayed high past one cycle on %s", t_name[i]);
      end
   endtask

   //----------------------------------------
   // main sequence
   //----------------------------------------
   initial
   begin
      err_cnt   = 0;
      n_load    = 0;
      wbm_rst_n <= 1'b0;
      wbm_cyc_i <= 1'b0;
      wbm_stb_i <= 1'b0;
      wbm_adr_i <= '0;
      wbm_we_i  <= 1'b0;
      wbm_dat_i <= '0;
      wbm_sel_i <= '0;
      exp_glb.raw = '0;                         // all peripherals in reset
      exp_bank    = wbh_pkg::BANK_RST_VAL;
      exp_clk1    = '0;
      exp_clk2    = '0;
      load_table();
      repeat (3) @(posedge wbm_clk_i);
      wbm_rst_n <= 1'b1;
      for (txn_idx = 0; txn_idx < N_TXN; txn_idx++)
      begin
         test_err = err_cnt;
         run_txn(txn_idx);
         if (err_cnt == test_err)
         begin
            $display("test %0d %s: ok", txn_idx, t_name[txn_idx]);
         end
         else
         begin
            $display("test %0d %s: failed", txn_idx, t_name[txn_idx]);
         end
      end
      $display("summary: %0d tests, %0d errors", N_TXN, err_cnt);
      if (err_cnt == 0)
      begin
         $display("TEST PASS");
      end
      else
      begin
         $display("TEST FAIL");
      end
      $finish;
   end

   // watchdog, bound from the table length
   initial
   begin
      #(CLK_PERIOD * (N_TXN * MAX_WAIT + 3));
      $display("watchdog: transfers did not finish in %0d cycles", N_TXN * MAX_WAIT);
      $display("TEST FAIL");
      $finish;
   end

endmodule

// File: compile.f
source/wbh_pkg.sv
source/wbh_req_ctrl.sv
source/wbh_reg_bank.sv
source/wbh_slave_fwd.sv
source/wb_host.sv
dv/tb_wbh_slave_model.sv
dv/tb_wb_host.sv

// File: run.sh
#!/usr/bin/env bash
# build the wishbone host testbench with verilator and run it
# the run passes only when the pass line shows up in the output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f compile.f --top-module tb_wb_host -o tb_wb_host \
   && ./obj_dir/tb_wb_host | tee /dev/stderr | grep -x "TEST PASS" > /dev/null \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }
